// File: build.f
+incdir+include
hdl/n64_vid_pkg.sv
hdl/n64_vphase.sv
hdl/n64_vdemux.sv
hdl/n64_pix_out.sv
hdl/n64_vin_top.sv
bench/tb_n64_vin.sv

// File: run.sh
#!/bin/sh
# build and run the video input testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_n64_vin -f build.f -Mdir obj_dir -o tb_n64_vin

out="$(./obj_dir/tb_n64_vin)"
printf '%s\n' "$out"

# pass only if the testbench printed its pass line
if printf '%s\n' "$out" | grep -qx 'TESTS PASSED'; then
  exit 0
fi
exit 1

// File: include/tb_n64_model.svh
// n64 video reference model
`ifndef TB_N64_MODEL_SVH
`define TB_N64_MODEL_SVH

//////////////////////////////
// random source
//////////////////////////////

// galois lfsr, 16 bit, taps 16 14 13 11
logic [15:0] lfsr_q = 16'd31;

function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 16'hB400;
  end
  return s >> 1;
endfunction

// one step per bit handed out
function automatic logic take_bit();
  lfsr_q = lfsr_step(lfsr_q);
  return lfsr_q[0];
endfunction

function automatic logic [color_w-1:0] take_bits(input int n);
  logic [color_w-1:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[color_w-2:0], take_bit()};
  end
  return v;
endfunction

//////////////////////////////
// model state
//////////////////////////////

// demux side
logic [sync_w-1:0]  m_sync;
logic [color_w-1:0] m_red;
logic [color_w-1:0] m_grn;
logic [color_w-1:0] m_blu;
// colour of the last pixel handed out, repeated while blanked
logic [color_w-1:0] m_out_r;
logic [color_w-1:0] m_out_g;
logic [color_w-1:0] m_out_b;
logic m_nblank;
logic m_rgb15;
logic m_sync_seen;
logic m_col_seen;
// colour cycles since the last sync word
int   m_gap;
// strobe and cadence error due in the next cycle
logic m_stb_pend;
logic m_err_pend;
logic [vdata_w-1:0] exp_q [$];

// one-entry output buffer
logic               m_valid;
logic               m_ovf;
logic [vdata_w-1:0] m_buf;

int chk_cnt;
int err_cnt;

task automatic model_reset();
  m_sync      = '0;
  m_red       = '0;
  m_grn       = '0;
  m_blu       = '0;
  m_out_r     = '0;
  m_out_g     = '0;
  m_out_b     = '0;
  m_nblank    = 1'b1;
  m_rgb15     = 1'b0;
  m_sync_seen = 1'b0;
  m_col_seen  = 1'b0;
  m_gap       = 0;
  m_stb_pend  = 1'b0;
  m_err_pend  = 1'b0;
  m_valid     = 1'b0;
  m_ovf       = 1'b0;
  m_buf       = '0;
  exp_q.delete();
endtask

//////////////////////////////
// demux rules, one bus word
//////////////////////////////

task automatic model_word(input logic nds, input vin_word_u w, input logic dbl_en,
                          input logic dbl_ph, input logic req);
  logic [sync_w-1:0]  s_new;
  logic [color_w-1:0] c;
  s_new      = w.sync[sync_w-1:0];
  m_stb_pend = 1'b0;
  if (!nds) begin
    // sync word due after exactly three colour cycles
    m_err_pend = m_sync_seen && (m_gap < 3);
    if (m_nblank) begin
      m_out_r = m_red;
      m_out_g = m_grn;
      m_out_b = m_blu;
    end
    if (m_col_seen) begin
      exp_q.push_back({m_sync, m_out_r, m_out_g, m_out_b});
      m_stb_pend = 1'b1;
    end
    // 15-bit request only counts at the start of a frame
    if (m_sync[sy_nvsync] && !s_new[sy_nvsync]) begin
      m_rgb15 = req;
    end
    if (!dbl_en) begin
      m_nblank = 1'b1;
    end else if (!m_sync[sy_ncsync] && s_new[sy_ncsync]) begin
      m_nblank = dbl_ph;
    end else begin
      m_nblank = !m_nblank;
    end
    m_sync      = s_new;
    m_sync_seen = 1'b1;
    m_col_seen  = 1'b0;
    m_gap       = 0;
  end else begin
    // fourth cycle without a sync word is late
    m_err_pend = m_sync_seen && (m_gap == 3);
    m_gap++;
    c = w.color;
    // two lowest bits are zero unless 15-bit mode is on
    if (!m_rgb15) begin
      c[1:0] = 2'b00;
    end
    case (m_gap)
      1:       m_red = c;
      2:       m_grn = c;
      default: m_blu = c;
    endcase
    m_col_seen = m_sync_seen;
  end
endtask

// buffer decision at the end of a cycle
task automatic model_buffer(input logic rdy);
  logic xfer;
  xfer = m_valid && rdy;
  if (m_stb_pend) begin
    if (!m_valid || xfer) begin
      m_buf   = exp_q.pop_front();
      m_valid = 1'b1;
    end else begin
      void'(exp_q.pop_front());
      m_ovf = 1'b1;
    end
  end else if (xfer) begin
    m_valid = 1'b0;
  end
endtask

//////////////////////////////
// compare tasks
//////////////////////////////

task automatic check_pix(input logic [vdata_w-1:0] got, input logic [vdata_w-1:0] exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("mismatch at %0t: pix_o is %h, model has %h", $time, got, exp);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("mismatch at %0t: %s is %b, model has %b", $time, name, got, exp);
  end
endtask

task automatic report_fail(input string msg);
  err_cnt++;
  $display("error at %0t: %s", $time, msg);
endtask

`endif

// File: bench/tb_n64_vin.sv
// n64 video input testbench
`timescale 1ns/100ps

module tb_n64_vin;

  import n64_vid_pkg::*;

  // pixels per test
  localparam int n_reset  = 4;
  localparam int n_demux  = 40;
  localparam int n_rgb15  = 24;
  localparam int n_deblur = 40;
  localparam int n_bp     = 60;
  localparam int n_cad    = 16;
  localparam int total_pix = n_reset + n_demux + n_rgb15 + n_deblur + n_bp + n_cad;
  // four bus cycles of 8 ns per pixel, 50% on top
  localparam int watchdog_ns = total_pix * 4 * 8 * 3 / 2;

  logic               VCLK = 1'b0;
  logic               rst_i;
  logic               ndsync_i;
  logic               deblur_en_i;
  logic               deblur_phase_i;
  logic               rgb15_req_i;
  logic               ready_i;
  vin_word_u          d_i;
  logic               valid_o;
  logic               overflow_o;
  logic               phase_err_o;
  logic [vdata_w-1:0] pix_o;

  // control values applied on the next bus cycle
  logic cfg_deblur_en;
  logic cfg_deblur_ph;
  logic cfg_rgb15_req;
  logic ready_rand;

  int tests_run;
  int tests_bad;
  int err_pulses;

  `include "tb_n64_model.svh"

  always #4 VCLK = ~VCLK;

  n64_vin_top uut (
    .VCLK           (VCLK),
    .rst_i          (rst_i),
    .ndsync_i       (ndsync_i),
    .deblur_en_i    (deblur_en_i),
    .deblur_phase_i (deblur_phase_i),
    .rgb15_req_i    (rgb15_req_i),
    .ready_i        (ready_i),
    .d_i            (d_i),
    .valid_o        (valid_o),
    .overflow_o     (overflow_o),
    .phase_err_o    (phase_err_o),
    .pix_o          (pix_o)
  );

  //////////////////////////////
  // bus cycle and pixel
  //////////////////////////////

  // drive on the rising edge, check in mid cycle
  task automatic bus_cycle(input logic nds, input vin_word_u w);
    @(posedge VCLK);
    ndsync_i       <= nds;
    d_i            <= w;
    deblur_en_i    <= cfg_deblur_en;
    deblur_phase_i <= cfg_deblur_ph;
    rgb15_req_i    <= cfg_rgb15_req;
    ready_i        <= ready_rand ? (take_bits(2) == 7'd3) : 1'b1;
    @(negedge VCLK);
    check_flag("valid_o", valid_o, m_valid);
    check_flag("overflow_o", overflow_o, m_ovf);
    check_flag("phase_err_o", phase_err_o, m_err_pend);
    if (m_valid) begin
      check_pix(pix_o, m_buf);
    end
    if (phase_err_o) begin
      err_pulses++;
    end
    model_buffer(ready_i);
    model_word(ndsync_i, d_i, deblur_en_i, deblur_phase_i, rgb15_req_i);
  endtask

  // sync word, then n_col colour words
  task automatic send_pixel(input logic nv, input logic ncs, input int n_col);
    vin_word_u w;
    w.sync = {3'b000, nv, take_bit(), take_bit(), ncs};
    bus_cycle(1'b0, w);
    for (int i = 0; i < n_col; i++) begin
      w.color = take_bits(color_w);
      bus_cycle(1'b1, w);
    end
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    tests_run++;
    if (err_cnt == errs_at_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, err_cnt - errs_at_start);
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    int        e0;
    vin_word_u idle;
    idle           = '0;
    rst_i          <= 1'b1;
    ndsync_i       <= 1'b1;
    d_i            <= '0;
    deblur_en_i    <= 1'b0;
    deblur_phase_i <= 1'b0;
    rgb15_req_i    <= 1'b0;
    ready_i        <= 1'b1;
    cfg_deblur_en  = 1'b0;
    cfg_deblur_ph  = 1'b0;
    cfg_rgb15_req  = 1'b0;
    ready_rand     = 1'b0;
    tests_run      = 0;
    tests_bad      = 0;
    err_pulses     = 0;
    chk_cnt        = 0;
    err_cnt        = 0;
    model_reset();
    repeat (3) @(posedge VCLK);
    rst_i <= 1'b0;

    // nothing may come out before a whole group
    e0 = err_cnt;
    bus_cycle(1'b1, idle);
    bus_cycle(1'b1, idle);
    for (int i = 0; i < n_reset; i++) begin
      send_pixel(1'b1, 1'b1, 3);
    end
    end_test("reset", e0);

    e0 = err_cnt;
    for (int i = 0; i < n_demux; i++) begin
      send_pixel(1'b1, take_bit(), 3);
    end
    end_test("demux", e0);

    // request mid frame, latch on nvsync fall at 8, off again at 16
    e0 = err_cnt;
    for (int i = 0; i < n_rgb15; i++) begin
      cfg_rgb15_req = (i >= 2) && (i < 12);
      send_pixel(!((i >= 8 && i < 12) || (i >= 16 && i < 20)), take_bit(), 3);
    end
    end_test("rgb15", e0);

    e0 = err_cnt;
    cfg_deblur_en = 1'b1;
    for (int i = 0; i < n_deblur; i++) begin
      cfg_deblur_ph = take_bit();
      send_pixel(1'b1, take_bit(), 3);
    end
    cfg_deblur_en = 1'b0;
    end_test("deblur", e0);

    // ready high one cycle in four on average
    e0 = err_cnt;
    ready_rand = 1'b1;
    for (int i = 0; i < n_bp; i++) begin
      send_pixel(1'b1, take_bit(), 3);
    end
    ready_rand = 1'b0;
    if (!overflow_o) begin
      report_fail("back-pressure never caused a dropped pixel");
    end
    end_test("backpressure", e0);

    // pixel 6 is one colour cycle short
    e0 = err_cnt;
    err_pulses = 0;
    for (int i = 0; i < n_cad; i++) begin
      send_pixel(1'b1, take_bit(), (i == 6) ? 2 : 3);
    end
    if (err_pulses != 1) begin
      report_fail("short nDSYNC period did not give exactly one phase error");
    end
    end_test("cadence", e0);

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_bad, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // stops a run that hangs
  initial begin
    #(watchdog_ns);
    $display("watchdog: the tests did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: hdl/n64_vin_top.sv
// n64 video input front end
`timescale 1ns/100ps

module n64_vin_top (
  input  logic                            VCLK,
  input  logic                            rst_i,
  input  logic                            ndsync_i,
  input  logic                            deblur_en_i,
  input  logic                            deblur_phase_i,
  input  logic                            rgb15_req_i,
  input  logic                            ready_i,
  input  n64_vid_pkg::vin_word_u          d_i,
  output logic                            valid_o,
  output logic                            overflow_o,
  output logic                            phase_err_o,
  output logic [n64_vid_pkg::vdata_w-1:0] pix_o
);

  import n64_vid_pkg::*;

  // phase tracker to demux
  phase_t phase;

  // demux to output stage
  logic [vdata_w-1:0] dmx_pix;
  logic               dmx_stb;

  n64_vphase u_vphase (
    .VCLK        (VCLK),
    .rst_i       (rst_i),
    .ndsync_i    (ndsync_i),
    .phase_o     (phase),
    .phase_err_o (phase_err_o)
  );

  n64_vdemux u_vdemux (
    .VCLK           (VCLK),
    .rst_i          (rst_i),
    .ndsync_i       (ndsync_i),
    .deblur_en_i    (deblur_en_i),
    .deblur_phase_i (deblur_phase_i),
    .rgb15_req_i    (rgb15_req_i),
    .d_i            (d_i),
    .phase_i        (phase),
    .pix_o          (dmx_pix),
    .pix_stb_o      (dmx_stb)
  );

  n64_pix_out u_pix_out (
    .VCLK       (VCLK),
    .rst_i      (rst_i),
    .pix_stb_i  (dmx_stb),
    .ready_i    (ready_i),
    .pix_i      (dmx_pix),
    .valid_o    (valid_o),
    .overflow_o (overflow_o),
    .pix_o      (pix_o)
  );

endmodule

// File: hdl/n64_pix_out.sv
// pixel output buffer
`timescale 1ns/100ps

module n64_pix_out (
  input  logic                            VCLK,
  input  logic                            rst_i,
  input  logic                            pix_stb_i,
  input  logic                            ready_i,
  input  logic [n64_vid_pkg::vdata_w-1:0] pix_i,
  output logic                            valid_o,
  output logic                            overflow_o,
  output logic [n64_vid_pkg::vdata_w-1:0] pix_o
);

  import n64_vid_pkg::*;

  //////////////////////////////
  // one-entry buffer
  //////////////////////////////

  logic               valid_q;
  logic [vdata_w-1:0] pix_q;
  logic               ovf_q;

  // handshake completes this cycle
  logic xfer;
  // buffer can take the incoming pixel
  logic load_ok;

  assign xfer    = valid_q && ready_i;
  assign load_ok = !valid_q || xfer;

  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      pix_q   <= '0;
      ovf_q   <= 1'b0;
    end else begin
      if (pix_stb_i) begin
        if (load_ok) begin
          // empty or draining right now
          pix_q   <= pix_i;
          valid_q <= 1'b1;
        end else begin
          // the bus cannot wait, the new pixel is lost
          ovf_q <= 1'b1;
        end
      end else if (xfer) begin
        valid_q <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign valid_o    = valid_q;
  assign pix_o      = pix_q;
  // sticky until reset
  assign overflow_o = ovf_q;

  // a stalled pixel stays put even when a strobe is dropped
  hold_a: assert property (@(posedge VCLK) disable iff (rst_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(pix_o)));

endmodule

// File: hdl/n64_vdemux.sv
// video bus demultiplexer
`timescale 1ns/100ps

module n64_vdemux (
  input  logic                                VCLK,
  input  logic                                rst_i,
  input  logic                                ndsync_i,
  input  logic                                deblur_en_i,
  input  logic                                deblur_phase_i,
  input  logic                                rgb15_req_i,
  input  n64_vid_pkg::vin_word_u              d_i,
  input  n64_vid_pkg::phase_t                 phase_i,
  output logic [n64_vid_pkg::vdata_w-1:0]     pix_o,
  output logic                                pix_stb_o
);

  import n64_vid_pkg::*;

  //////////////////////////////
  // capture registers
  //////////////////////////////

  // sync and colour of the pixel being collected
  logic [sync_w-1:0]  sync_q;
  logic [color_w-1:0] red_q;
  logic [color_w-1:0] grn_q;
  logic [color_w-1:0] blu_q;

  // finished pixel
  logic [vdata_w-1:0] pix_q;
  logic               stb_q;

  // 1 lets colour through, 0 repeats the previous colour
  logic nblank_q;
  logic rgb15_q;

  // a sync word was captured since reset
  logic sync_seen_q;
  // a colour cycle followed that sync word
  logic col_seen_q;

  logic               sync_cyc;
  logic               ncsync_rise;
  logic               nvsync_fall;
  logic [sync_w-1:0]  sync_new;
  logic [color_w-1:0] col_val;

  assign sync_cyc = !ndsync_i;

  // sync bits in pixel order
  assign sync_new = {d_i.sync[sy_nvsync], d_i.sync[sy_nclamp],
                     d_i.sync[sy_nhsync], d_i.sync[sy_ncsync]};

  // edges against the previously captured sync word
  assign ncsync_rise = !sync_q[sy_ncsync] && d_i.sync[sy_ncsync];
  assign nvsync_fall = sync_q[sy_nvsync] && !d_i.sync[sy_nvsync];

  // 21-bit colour keeps the upper five bits only
  assign col_val = rgb15_q ? d_i.color :
                   {d_i.color[color_w-1:rgb_drop_w], {rgb_drop_w{1'b0}}};

  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      sync_q      <= '0;
      red_q       <= '0;
      grn_q       <= '0;
      blu_q       <= '0;
      pix_q       <= '0;
      stb_q       <= 1'b0;
      nblank_q    <= 1'b1;
      rgb15_q     <= 1'b0;
      sync_seen_q <= 1'b0;
      col_seen_q  <= 1'b0;
    end else begin
      stb_q <= sync_cyc && col_seen_q;
      if (sync_cyc) begin
        // hand the collected pixel to the output register
        pix_q[sync_lsb +: sync_w] <= sync_q;
        if (nblank_q) begin
          pix_q[red_lsb   +: color_w] <= red_q;
          pix_q[green_lsb +: color_w] <= grn_q;
          pix_q[blue_lsb  +: color_w] <= blu_q;
        end
        sync_q      <= sync_new;
        sync_seen_q <= 1'b1;
        col_seen_q  <= 1'b0;
        // new frame, new colour depth
        if (nvsync_fall) begin
          rgb15_q <= rgb15_req_i;
        end
        // deblur blanks every other pixel, realigned per line
        if (!deblur_en_i) begin
          nblank_q <= 1'b1;
        end else if (ncsync_rise) begin
          nblank_q <= deblur_phase_i;
        end else begin
          nblank_q <= !nblank_q;
        end
      end else begin
        col_seen_q <= sync_seen_q;
        case (phase_i)
          ph_red:   red_q <= col_val;
          ph_green: grn_q <= col_val;
          ph_blue:  blu_q <= col_val;
          default:  blu_q <= blu_q;
        endcase
      end
    end
  end

  assign pix_o     = pix_q;
  assign pix_stb_o = stb_q;

  // every pixel needs a sync cycle and at least one colour cycle
  stb_gap_a: assert property (@(posedge VCLK) disable iff (rst_i)
    pix_stb_o |=> !pix_stb_o);

endmodule

// File: hdl/n64_vphase.sv
// video bus phase tracker
`timescale 1ns/100ps

module n64_vphase (
  input  logic                VCLK,
  input  logic                rst_i,
  input  logic                ndsync_i,
  output n64_vid_pkg::phase_t phase_o,
  output logic                phase_err_o
);

  import n64_vid_pkg::*;

  //////////////////////////////
  // cadence counter
  //////////////////////////////

  // predicted position of the current cycle
  // ph_sync here means a sync word is due (or overdue)
  phase_t     pos_q;
  phase_t     pos_d;
  logic [1:0] pos_inc;

  // set while waiting for nDSYNC without expecting it
  // covers the time after reset and a late nDSYNC
  logic wait_q;

  logic err_early;
  logic err_late;
  logic err_q;

  assign pos_inc = pos_q + 2'd1;

  always_comb begin
    if (!ndsync_i) begin
      // sync seen, the red word follows
      pos_d = ph_red;
    end else if (pos_q == ph_sync) begin
      // overdue, keep waiting for the sync word
      pos_d = ph_sync;
    end else begin
      // blue wraps to ph_sync
      pos_d = phase_t'(pos_inc);
    end
  end

  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      pos_q  <= ph_sync;
      wait_q <= 1'b1;
    end else begin
      pos_q <= pos_d;
      if (!ndsync_i) begin
        wait_q <= 1'b0;
      end else if (pos_q == ph_sync) begin
        wait_q <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // phase output
  //////////////////////////////

  // an overdue cycle keeps writing blue until the sync word shows up
  assign phase_o = !ndsync_i         ? ph_sync :
                   (pos_q == ph_sync) ? ph_blue : pos_q;

  //////////////////////////////
  // cadence errors
  //////////////////////////////

  // sync word in a colour slot
  assign err_early = !ndsync_i && (pos_q != ph_sync);

  // first missing sync word, flagged once per gap
  assign err_late = ndsync_i && (pos_q == ph_sync) && !wait_q;

  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= err_early || err_late;
    end
  end

  assign phase_err_o = err_q;

  // a sync word on the four-cycle cadence is never flagged
  cadence_a: assert property (@(posedge VCLK) disable iff (rst_i)
    (!ndsync_i && $past(ndsync_i, 1) && $past(ndsync_i, 2) && $past(ndsync_i, 3)
     && !$past(ndsync_i, 4)) |=> !phase_err_o);

endmodule

// File: hdl/n64_vid_pkg.sv
// n64 video input definitions

package n64_vid_pkg;

  //////////////////////////////
  // bus and pixel widths
  //////////////////////////////

  // one colour component, same as the console bus
  localparam int color_w = 7;

  // sync bits carried with every pixel
  localparam int sync_w = 4;

  // sync plus red, green and blue
  localparam int vdata_w = sync_w + 3 * color_w;

  // field offsets inside a demultiplexed pixel
  // msb first: sync, red, green, blue
  localparam int blue_lsb  = 0;
  localparam int green_lsb = color_w;
  localparam int red_lsb   = 2 * color_w;
  localparam int sync_lsb  = 3 * color_w;

  // lsbs cleared while 15-bit mode is off
  localparam int rgb_drop_w = 2;

  //////////////////////////////
  // input word decode
  //////////////////////////////

  // bit positions of the sync view
  // bits 6..4 carry nothing in a sync cycle
  localparam int sy_ncsync = 0;
  localparam int sy_nhsync = 1;
  localparam int sy_nclamp = 2;
  localparam int sy_nvsync = 3;

  // one bus word, read as sync bits in the sync cycle
  // and as a colour value in the three colour cycles
  typedef union packed {
    logic [color_w-1:0] sync;
    logic [color_w-1:0] color;
  } vin_word_u;

  //////////////////////////////
  // demux phase
  //////////////////////////////

  // position of the current bus cycle within one pixel
  typedef enum logic [1:0] {
    ph_sync  = 2'd0,
    ph_red   = 2'd1,
    ph_green = 2'd2,
    ph_blue  = 2'd3
  } phase_t;

endpackage
